//--- hdl/lsuOpPkg.sv
package lsuOpPkg;

  // Access size, taken from the low two bits of funct3
  typedef enum logic [1:0] {
    sizeByte = 2'b00,
    sizeHalf = 2'b01,
    sizeWord = 2'b10
  } memSizeT;

  // Load operations, bit 2 set marks a zero-extended load
  localparam logic [2:0] LB  = 3'b000;
  localparam logic [2:0] LH  = 3'b001;
  localparam logic [2:0] LW  = 3'b010;
  localparam logic [2:0] LBU = 3'b100;
  localparam logic [2:0] LHU = 3'b101;

  // Store operations
  localparam logic [2:0] SB  = 3'b000;
  localparam logic [2:0] SH  = 3'b001;
  localparam logic [2:0] SW  = 3'b010;

  function automatic memSizeT sizeOf(input logic [2:0] funct3);
    return memSizeT'(funct3[1:0]);
  endfunction

endpackage

//--- hdl/memGeomPkg.sv
package memGeomPkg;

  // Data word width in bits
  parameter int wordBits = 32;

  // Bytes per line, a spill is an access across this boundary
  parameter int lineBytes = 16;

  // RAM depth in words and byte address width
  parameter int ramWords = 256;
  parameter int adrBits  = 10;

endpackage

//--- hdl/memPortIf.sv
interface memPortIf #(
  parameter int LLEN = 32,
  parameter int ADRW = 10
);

  // Byte address of the lower word, always word aligned
  logic [ADRW-1:0]       adr;
  // Lower word in the low half, in-line successor in the high half
  logic [2*LLEN/8-1:0]   byteMask;
  logic [2*LLEN-1:0]     writeData;
  logic                  write;
  logic [2*LLEN-1:0]     readData;

  // Alignment unit side
  modport requester (
    output adr, byteMask, writeData, write,
    input  readData
  );

  // RAM side
  modport memory (
    input  adr, byteMask, writeData, write,
    output readData
  );

endinterface

//--- hdl/byteMaskGen.sv
module byteMaskGen #(
  parameter int LLEN = 32
) (
  input  lsuOpPkg::memSizeT        size,
  input  logic [$clog2(LLEN/8)-1:0] byteOffset,
  output logic [LLEN/8-1:0]        byteMask,
  output logic [LLEN/8-1:0]        byteMaskExt
);

  localparam int BYTES = LLEN / 8;

  // Run of ones at byte 0 over a two-word window
  logic [2*BYTES-1:0] run;
  // Run moved to the access offset
  logic [2*BYTES-1:0] window;

  always_comb begin
    run = '0;
    case (size)
      lsuOpPkg::sizeByte: run[0]   = 1'b1;
      lsuOpPkg::sizeHalf: run[1:0] = 2'b11;
      lsuOpPkg::sizeWord: run[3:0] = 4'b1111;
      // Unused size code covers the whole word
      default:            run[BYTES-1:0] = '1;
    endcase
  end

  // Bytes past the word end land in the upper half
  assign window = run << byteOffset;

  // Upper half feeds the second spill cycle or an in-line misaligned access
  assign byteMask    = window[BYTES-1:0];
  assign byteMaskExt = window[2*BYTES-1:BYTES];

endmodule

//--- hdl/alignUnit.sv
module alignUnit #(
  parameter int LLEN      = 32,
  parameter int LINEBYTES = 16,
  parameter int ADRW      = 10
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 reqValid,
  input  logic                 write,
  input  logic [2:0]           funct3,
  input  logic [ADRW-1:0]      adr,
  input  logic [LLEN-1:0]      writeData,
  input  logic [LLEN/8-1:0]    byteMask,
  input  logic [LLEN/8-1:0]    byteMaskExt,
  output logic [LLEN-1:0]      alignedData,
  output logic                 stall,
  memPortIf.requester          mem
);

  localparam int BYTES = LLEN / 8;
  localparam int BOFS  = $clog2(BYTES);
  localparam int LOFS  = $clog2(LINEBYTES);

  typedef enum logic {stReady, stSpill} spillStateT;

  spillStateT             curState;
  spillStateT             nextState;
  lsuOpPkg::memSizeT      size;
  logic [BOFS-1:0]        byteOffset;
  logic [BOFS+2:0]        shiftAmt;
  logic                   halfMis;
  logic                   wordMis;
  logic                   spillReq;
  logic                   selSpill;
  logic [ADRW-1:0]        wordAdr;
  logic [LLEN-1:0]        firstWord;
  logic [2*BYTES-1:0]     maskSave;
  logic [2*BYTES-1:0]     maskMux;
  logic [2*LLEN-1:0]      readAll;
  logic [2*LLEN-1:0]      readShift;
  logic [3*LLEN-1:0]      writeExt;

  ////////////////////////////////////////
  // Spill detection
  ////////////////////////////////////////

  assign size       = lsuOpPkg::sizeOf(funct3);
  assign byteOffset = adr[BOFS-1:0];

  // Misaligned when offset bits below the size are nonzero
  assign halfMis = (size == lsuOpPkg::sizeHalf) & adr[0];
  assign wordMis = (size == lsuOpPkg::sizeWord) & (adr[BOFS-1:0] != '0);

  // Spill when the access also starts in the last word or half of the line
  assign spillReq = reqValid &
                    ((halfMis & (adr[LOFS-1:1] == '1)) |
                     (wordMis & (adr[LOFS-1:BOFS] == '1)));

  ////////////////////////////////////////
  // Spill sequencing
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      curState <= stReady;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    case (curState)
      stReady: nextState = spillReq ? stSpill : stReady;
      // Second half always takes exactly one cycle
      stSpill: nextState = stReady;
      default: nextState = stReady;
    endcase
  end

  assign selSpill = (curState == stSpill);

  // Hold the requester only in the first cycle of a spill
  assign stall = (curState == stReady) & spillReq;

  // Second cycle goes to the first word of the next line
  assign wordAdr = {adr[ADRW-1:BOFS], {BOFS{1'b0}}};
  assign mem.adr = selSpill ? wordAdr + ADRW'(BYTES) : wordAdr;

  // Lower word and both masks captured while stalled
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      firstWord <= '0;
      maskSave  <= '0;
    end else if (stall) begin
      firstWord <= mem.readData[LLEN-1:0];
      maskSave  <= {byteMaskExt, byteMask};
    end
  end

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////

  // During a spill the new lower word sits above the saved one
  assign readAll = selSpill ? {mem.readData[LLEN-1:0], firstWord} : mem.readData;

  // Byte shift of the whole two-word window
  assign shiftAmt    = {byteOffset, 3'b000};
  assign readShift   = readAll >> shiftAmt;
  assign alignedData = readShift[LLEN-1:0];

  ////////////////////////////////////////
  // Write path
  ////////////////////////////////////////

  // Three copies so both output words see the rotated store data
  assign writeExt      = {writeData, writeData, writeData} << shiftAmt;
  assign mem.writeData = writeExt[3*LLEN-1:LLEN];
  assign mem.write     = reqValid & write;

  // Saved mask in the spill cycle, live mask otherwise
  assign maskMux = selSpill ? maskSave : {byteMaskExt, byteMask};

  always_comb begin
    if (selSpill) begin
      // Upper bytes moved into the lower word of the next line
      mem.byteMask = {{BYTES{1'b0}}, maskMux[2*BYTES-1:BYTES]};
    end else if (stall) begin
      // First spill cycle only touches the end of the current line
      mem.byteMask = {{BYTES{1'b0}}, maskMux[BYTES-1:0]};
    end else begin
      mem.byteMask = maskMux;
    end
  end

endmodule

//--- hdl/dataRam.sv
module dataRam #(
  parameter int LLEN      = 32,
  parameter int LINEBYTES = 16,
  parameter int DEPTH     = 256
) (
  input  logic        clk,
  input  logic        arstN,
  memPortIf.memory    mem
);

  localparam int BYTES = LLEN / 8;
  localparam int BOFS  = $clog2(BYTES);
  localparam int IDXW  = $clog2(DEPTH);
  localparam int LWW   = $clog2(LINEBYTES / BYTES);

  logic [LLEN-1:0] words [DEPTH];
  logic [IDXW-1:0] idx;
  logic [IDXW-1:0] nextIdx;
  logic            lastInLine;

  assign idx = mem.adr[BOFS +: IDXW];

  // Successor stays inside the line, last word reads itself again
  assign lastInLine = (idx[LWW-1:0] == '1);
  assign nextIdx    = lastInLine ? idx : idx + 1'b1;

  assign mem.readData = {words[nextIdx], words[idx]};

  // Byte-enabled write of the word and its in-line successor
  always_ff @(posedge clk) begin
    // Writes are ignored while reset is held
    if (arstN && mem.write) begin
      for (int b = 0; b < BYTES; b++) begin
        if (mem.byteMask[b]) begin
          words[idx][8*b +: 8] <= mem.writeData[8*b +: 8];
        end
      end
      for (int b = 0; b < BYTES; b++) begin
        // Upper half is dropped at the end of a line
        if (mem.byteMask[BYTES+b] && !lastInLine) begin
          words[nextIdx][8*b +: 8] <= mem.writeData[LLEN + 8*b +: 8];
        end
      end
    end
  end

endmodule

//--- hdl/loadExtend.sv
module loadExtend #(
  parameter int LLEN = 32
) (
  input  logic [2:0]      funct3,
  input  logic [LLEN-1:0] alignedData,
  output logic [LLEN-1:0] loadData
);

  // Sign bits are forced to zero for unsigned loads
  logic byteSign;
  logic halfSign;

  assign byteSign = ~funct3[2] & alignedData[7];
  assign halfSign = ~funct3[2] & alignedData[15];

  always_comb begin
    case (lsuOpPkg::sizeOf(funct3))
      lsuOpPkg::sizeByte: loadData = {{(LLEN-8){byteSign}}, alignedData[7:0]};
      lsuOpPkg::sizeHalf: loadData = {{(LLEN-16){halfSign}}, alignedData[15:0]};
      // Full word needs no extension
      default:            loadData = alignedData;
    endcase
  end

endmodule

//--- hdl/lsuTop.sv
module lsuTop #(
  parameter int LLEN      = memGeomPkg::wordBits,
  parameter int LINEBYTES = memGeomPkg::lineBytes,
  parameter int DEPTH     = memGeomPkg::ramWords,
  parameter int ADRW      = memGeomPkg::adrBits
) (
  input  logic            clk,
  input  logic            arstN,
  input  logic            reqValid,
  input  logic            write,
  input  logic [2:0]      funct3,
  input  logic [ADRW-1:0] adr,
  input  logic [LLEN-1:0] writeData,
  output logic [LLEN-1:0] loadData,
  output logic            stall
);

  logic [LLEN/8-1:0] byteMask;
  logic [LLEN/8-1:0] byteMaskExt;
  logic [LLEN-1:0]   alignedData;

  ////////////////////////////////////////
  // Two-word port between aligner and RAM
  ////////////////////////////////////////

  memPortIf #(.LLEN(LLEN), .ADRW(ADRW)) memPort ();

  // Mask over the access window from size and byte offset
  byteMaskGen #(.LLEN(LLEN)) uMaskGen (
    .size        (lsuOpPkg::sizeOf(funct3)),
    .byteOffset  (adr[$clog2(LLEN/8)-1:0]),
    .byteMask    (byteMask),
    .byteMaskExt (byteMaskExt)
  );

  alignUnit #(.LLEN(LLEN), .LINEBYTES(LINEBYTES), .ADRW(ADRW)) uAlign (
    .clk         (clk),
    .arstN       (arstN),
    .reqValid    (reqValid),
    .write       (write),
    .funct3      (funct3),
    .adr         (adr),
    .writeData   (writeData),
    .byteMask    (byteMask),
    .byteMaskExt (byteMaskExt),
    .alignedData (alignedData),
    .stall       (stall),
    .mem         (memPort.requester)
  );

  dataRam #(.LLEN(LLEN), .LINEBYTES(LINEBYTES), .DEPTH(DEPTH)) uRam (
    .clk   (clk),
    .arstN (arstN),
    .mem   (memPort.memory)
  );

  // Sign or zero extension of the shifted load
  loadExtend #(.LLEN(LLEN)) uExtend (
    .funct3      (funct3),
    .alignedData (alignedData),
    .loadData    (loadData)
  );

endmodule

//--- test/lsuTb.sv
module lsuTb;

  localparam int LLEN      = memGeomPkg::wordBits;
  localparam int LINEBYTES = memGeomPkg::lineBytes;
  localparam int DEPTH     = memGeomPkg::ramWords;
  localparam int ADRW      = memGeomPkg::adrBits;
  localparam int MEMBYTES  = 1 << ADRW;
  // Longest stall the requester tolerates before giving up
  localparam int STALLLIMIT = 8;

  logic            clk;
  logic            arstN;
  logic            reqValid;
  logic            write;
  logic [2:0]      funct3;
  logic [ADRW-1:0] adr;
  logic [LLEN-1:0] writeData;
  logic [LLEN-1:0] loadData;
  logic            stall;

  // Reference memory, one entry per byte, little endian
  logic [7:0] memModel [MEMBYTES];

  int loadErrors;
  int stallErrors;
  int timeouts;
  bit stopRun;

  lsuTop #(.LLEN(LLEN), .LINEBYTES(LINEBYTES), .DEPTH(DEPTH), .ADRW(ADRW)) dut (
    .clk       (clk),
    .arstN     (arstN),
    .reqValid  (reqValid),
    .write     (write),
    .funct3    (funct3),
    .adr       (adr),
    .writeData (writeData),
    .loadData  (loadData),
    .stall     (stall)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Access width in bytes from the size field of funct3
  function automatic int accessBytes(input logic [2:0] op);
    case (op[1:0])
      2'b00:   return 1;
      2'b01:   return 2;
      default: return 4;
    endcase
  endfunction

  function automatic logic [LLEN-1:0] modelLoad(input logic [2:0] op, input int a);
    logic [LLEN-1:0] value;
    int              n;
    n     = accessBytes(op);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value[8*i +: 8] = memModel[(a + i) % MEMBYTES];
    end
    // Signed loads copy the top loaded bit upward
    if (!op[2]) begin
      for (int k = 8*n; k < LLEN; k++) begin
        value[k] = value[8*n-1];
      end
    end
    return value;
  endfunction

  function automatic void modelStore(input logic [2:0] op, input int a,
                                     input logic [LLEN-1:0] data);
    for (int i = 0; i < accessBytes(op); i++) begin
      memModel[(a + i) % MEMBYTES] = data[8*i +: 8];
    end
  endfunction

  // One stall cycle when a misaligned access runs past the end of its line
  function automatic int modelStallCycles(input logic [2:0] op, input int a);
    int n;
    n = accessBytes(op);
    return (((a % n) != 0) && ((a % LINEBYTES) + n > LINEBYTES)) ? 1 : 0;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic checkLoad(input logic [ADRW-1:0] a, input logic [LLEN-1:0] expected,
                           input logic [LLEN-1:0] actual);
    if (actual !== expected) begin
      loadErrors++;
      $display("ERROR loadData adr=0x%h expected 0x%h got 0x%h", a, expected, actual);
    end
  endtask

  task automatic checkStall(input logic [ADRW-1:0] a, input int expected, input int actual);
    if (actual != expected) begin
      stallErrors++;
      $display("ERROR stall cycles adr=0x%h expected 0x%0h got 0x%0h", a, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  function automatic logic [2:0] pickOp(input logic isWrite);
    logic [2:0] loads [5];
    logic [2:0] stores [3];
    loads  = '{lsuOpPkg::LB, lsuOpPkg::LH, lsuOpPkg::LW, lsuOpPkg::LBU, lsuOpPkg::LHU};
    stores = '{lsuOpPkg::SB, lsuOpPkg::SH, lsuOpPkg::SW};
    return isWrite ? stores[$urandom_range(0, 2)] : loads[$urandom_range(0, 4)];
  endfunction

  // Half of the addresses land in the last three bytes of a line
  function automatic logic [ADRW-1:0] pickAdr();
    int lineBase;
    if ($urandom_range(0, 1) == 1) begin
      lineBase = $urandom_range(0, MEMBYTES/LINEBYTES - 1) * LINEBYTES;
      return ADRW'(lineBase + LINEBYTES - $urandom_range(1, 3));
    end
    return ADRW'($urandom_range(0, MEMBYTES - 1));
  endfunction

  // Cycle with no request, random fields must not raise stall
  task automatic idleCycle();
    @(posedge clk);
    reqValid  <= 1'b0;
    write     <= 1'(($urandom_range(0, 1)));
    funct3    <= 3'($urandom_range(0, 7));
    adr       <= pickAdr();
    writeData <= LLEN'($urandom());
    @(negedge clk);
    checkStall(adr, 0, (stall === 1'b0) ? 0 : 1);
  endtask

  // One request, held until stall drops, then checked against the model
  task automatic runAccess(input logic isWrite, input logic [2:0] op,
                           input logic [ADRW-1:0] a, input logic [LLEN-1:0] wd);
    int stallCount;
    @(posedge clk);
    reqValid  <= 1'b1;
    write     <= isWrite;
    funct3    <= op;
    adr       <= a;
    writeData <= wd;
    @(negedge clk);
    stallCount = 0;
    while (stall !== 1'b0 && stallCount < STALLLIMIT) begin
      stallCount++;
      @(negedge clk);
    end
    if (stall !== 1'b0) begin
      timeouts++;
      stopRun = 1'b1;
      $display("Timeout: stall stayed high for %0d cycles at adr 0x%h", stallCount, a);
    end else begin
      checkStall(a, modelStallCycles(op, int'(a)), stallCount);
      if (isWrite) begin
        // RAM takes the store at the next rising edge
        modelStore(op, int'(a), wd);
      end else begin
        checkLoad(a, modelLoad(op, int'(a)), loadData);
      end
    end
  endtask

  initial begin
    logic            isWrite;
    logic [2:0]      op;
    logic [ADRW-1:0] a;
    logic [ADRW-1:0] base;
    int              i;
    clk       = 1'b0;
    arstN     = 1'b0;
    reqValid  = 1'b0;
    write     = 1'b0;
    funct3    = 3'b000;
    adr       = '0;
    writeData = '0;
    loadErrors  = 0;
    stallErrors = 0;
    timeouts    = 0;
    stopRun     = 1'b0;
    for (i = 0; i < MEMBYTES; i++) begin
      memModel[i] = 8'h00;
    end
    void'($urandom(32'hd16b_0f5e));

    repeat (2) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    checkStall(adr, 0, (stall === 1'b0) ? 0 : 1);

    // Loads straight after reset read an all-zero RAM
    for (i = 0; i < 48 && !stopRun; i++) begin
      runAccess(1'b0, pickOp(1'b0), pickAdr(), '0);
    end

    // Mixed traffic, each store followed by loads of its two words
    for (i = 0; i < 1500 && !stopRun; i++) begin
      if ($urandom_range(0, 7) == 0) begin
        idleCycle();
      end
      isWrite = ($urandom_range(0, 9) < 4);
      op      = pickOp(isWrite);
      a       = pickAdr();
      runAccess(isWrite, op, a, LLEN'($urandom()));
      if (isWrite && !stopRun) begin
        base = a & ~ADRW'(LLEN/8 - 1);
        runAccess(1'b0, lsuOpPkg::LW, base, '0);
        runAccess(1'b0, lsuOpPkg::LW, base + ADRW'(LLEN/8), '0);
      end
    end

    @(posedge clk);
    reqValid <= 1'b0;
    @(negedge clk);

    $display("Errors: load=%0d stall=%0d timeout=%0d", loadErrors, stallErrors, timeouts);
    if (loadErrors + stallErrors + timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- lsuAlign.f
hdl/lsuOpPkg.sv
hdl/memGeomPkg.sv
hdl/memPortIf.sv
hdl/byteMaskGen.sv
hdl/alignUnit.sv
hdl/dataRam.sv
hdl/loadExtend.sv
hdl/lsuTop.sv
test/lsuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the LSU alignment testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --x-initial 0 \
  -f lsuAlign.f --top-module lsuTb -o lsuSim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/lsuSim > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
  exit 1
fi
exit 0
